/* common/cache_settings.svh */
// cache geometry and memory model sizes, shared by package, RTL and testbench
// TAG_W + log2(CACHE_SETS) + 3 must equal 32 for the address split

`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry, two ways of two-word blocks
`define CACHE_SETS 8
`define TAG_W 26

// main memory model
`define MEM_WORDS 4096      // upper address bits wrap
`define MEM_LATENCY 2       // wait cycles per word, 0 allowed

// hit count lands here once the flush is done
`define HIT_COUNT_ADDR 32'h0000_3100

`endif

/* common/cache_types_pkg.sv */
// shared types for the data cache, its memory and the snoop port
// field widths follow the macros in cache_settings.svh
`default_nettype none

`include "cache_settings.svh"

package cache_types_pkg;

    typedef logic [31:0] word_t;

    // address split as seen by the cache
    typedef struct packed {
        logic [`TAG_W-1:0]               tag;
        logic [$clog2(`CACHE_SETS)-1:0]  idx;
        logic                            blkoff;  // word within block
        logic [1:0]                      bytoff;
    } dcache_addr_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } dp_req_t;

    typedef struct packed {
        logic  dhit;
        word_t load;
    } dp_resp_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } mem_req_t;

    typedef struct packed {
        logic  dwait;   // low for one cycle when the word completes
        word_t load;
    } mem_resp_t;

    typedef struct packed {
        logic  active;  // ccwait level
        logic  inv;
        word_t addr;
    } snoop_req_t;

    typedef enum logic [3:0] {
        IDLE, WB1, WB2, RD1, RD2, FLCHK, FL1, FL2, CNTW, STOP
    } cache_state_e;

endpackage

`default_nettype wire

/* logic/memory_ram.sv */
// word memory with MEM_LATENCY wait cycles per access, contents not reset
// a request must be held until dwait drops, dropping it early restarts the count
`default_nettype none

`include "cache_settings.svh"

module memory_ram import cache_types_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  mem_req_t  mem_req,
    output mem_resp_t mem_resp
);

    localparam int AW    = $clog2(`MEM_WORDS);
    localparam int CNT_W = (`MEM_LATENCY > 0) ? $clog2(`MEM_LATENCY + 1) : 1;

    word_t mem [`MEM_WORDS];

    logic [CNT_W-1:0] wait_cnt;
    logic [AW-1:0]    word_idx;
    logic             req;
    logic             done;

    assign req      = mem_req.ren | mem_req.wen;
    assign word_idx = mem_req.addr[AW+1:2];     // byte offset dropped, high bits ignored
    assign done     = req && (wait_cnt == CNT_W'(`MEM_LATENCY));

    assign mem_resp.dwait = req & ~done;
    assign mem_resp.load  = (mem_req.ren && done) ? mem[word_idx] : '0;

    // wait counter, clears on completion or when the request goes away
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (!req || done) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // write commits in the cycle dwait is low
    always_ff @(posedge CLK) begin
        if (mem_req.wen && done)
            mem[word_idx] <= mem_req.store;
    end

endmodule

`default_nettype wire

/* dcache/dcache.sv */
// two-way write-back data cache, two-word blocks, whole-word accesses only
// an invalidating snoop drops the block along with its dirty data
`default_nettype none

`include "cache_settings.svh"

module dcache import cache_types_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  dp_req_t    dp_req,
    input  logic       halt,
    output dp_resp_t   dp_resp,
    output logic       flushed,
    output mem_req_t   mem_req,
    input  mem_resp_t  mem_resp,
    input  snoop_req_t snoop,
    output logic       ccwrite,
    output word_t      snoop_data
);

    localparam int IDX_W = $clog2(`CACHE_SETS);
    localparam int ROW_W = IDX_W + 1;   // set index plus way
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(2 * `CACHE_SETS - 1);

    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
        word_t [1:0]       data;
        logic              dirty;
    } frame_t;

    typedef struct packed {
        frame_t [1:0] frame;
        logic         lru;      // way to replace next
    } set_t;

    set_t [`CACHE_SETS-1:0] sets;
    set_t [`CACHE_SETS-1:0] nxt_sets;

    cache_state_e state, nxt_state;
    cache_state_e prev_state;   // last state outside a snoop

    logic [ROW_W-1:0] row, nxt_row;     // flush position, set*2 + way
    word_t hit_count, nxt_hit_count;

    dcache_addr_t dp_addr;
    dcache_addr_t snp_addr;
    logic         dp_access;
    logic [1:0]   dp_match;
    logic [1:0]   snp_match;
    logic         dp_hit;
    logic         dp_way;
    logic         snp_way;
    logic         victim;
    frame_t       victim_frame;
    logic [IDX_W-1:0] fl_idx;
    logic         fl_way;
    frame_t       fl_frame;

    // word address of one half of a block
    function automatic word_t blk_addr(
        input logic [`TAG_W-1:0] tag,
        input logic [IDX_W-1:0]  idx,
        input logic              blk
    );
        dcache_addr_t a;
        a.tag    = tag;
        a.idx    = idx;
        a.blkoff = blk;
        a.bytoff = 2'b00;
        return word_t'(a);
    endfunction

    assign dp_addr   = dcache_addr_t'(dp_req.addr);
    assign snp_addr  = dcache_addr_t'(snoop.addr);
    assign dp_access = dp_req.ren | dp_req.wen;

    // tag compare for datapath and snoop side
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            dp_match[w]  = sets[dp_addr.idx].frame[w].valid &&
                           (sets[dp_addr.idx].frame[w].tag == dp_addr.tag);
            snp_match[w] = sets[snp_addr.idx].frame[w].valid &&
                           (sets[snp_addr.idx].frame[w].tag == snp_addr.tag);
        end
    end

    assign dp_hit  = |dp_match;
    assign dp_way  = ~dp_match[0];     // way 0 wins if both match
    assign snp_way = ~snp_match[0];

    // victim stays fixed for the whole miss, nothing moves lru meanwhile
    assign victim       = sets[dp_addr.idx].lru;
    assign victim_frame = sets[dp_addr.idx].frame[victim];

    assign fl_idx   = row[ROW_W-1:1];
    assign fl_way   = row[0];
    assign fl_frame = sets[fl_idx].frame[fl_way];

    assign ccwrite    = snoop.active & (|snp_match);
    assign snoop_data = ccwrite ? sets[snp_addr.idx].frame[snp_way].data[snp_addr.blkoff]
                                : '0;
    assign flushed    = (state == STOP);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= IDLE;
            prev_state <= IDLE;
            sets       <= '0;
            row        <= '0;
            hit_count  <= '0;
        end else begin
            state     <= nxt_state;
            sets      <= nxt_sets;
            row       <= nxt_row;
            hit_count <= nxt_hit_count;
            if (!snoop.active)
                prev_state <= state;    // snoop cycles are invisible here
        end
    end

    always_comb begin
        nxt_sets      = sets;
        nxt_state     = state;
        nxt_row       = row;
        nxt_hit_count = hit_count;
        dp_resp       = '0;
        mem_req       = '0;

        if (snoop.active) begin
            // bus belongs to the snooper, FSM holds
            mem_req.addr = snoop.addr;
            if (snoop.inv && ccwrite) begin
                nxt_sets[snp_addr.idx].frame[snp_way].valid = 1'b0;
                nxt_sets[snp_addr.idx].frame[snp_way].dirty = 1'b0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (halt) begin
                        nxt_state = FLCHK;
                    end else if (dp_access) begin
                        if (dp_hit) begin
                            dp_resp.dhit = 1'b1;
                            if (dp_req.ren)
                                dp_resp.load = sets[dp_addr.idx].frame[dp_way].data[dp_addr.blkoff];
                            if (dp_req.wen) begin
                                nxt_sets[dp_addr.idx].frame[dp_way].data[dp_addr.blkoff] =
                                    dp_req.store;
                                nxt_sets[dp_addr.idx].frame[dp_way].dirty = 1'b1;
                            end
                            nxt_sets[dp_addr.idx].lru = ~dp_way;
                            // the hit right after a refill is the miss itself
                            if (prev_state != RD2)
                                nxt_hit_count = hit_count + 32'd1;
                        end else if (victim_frame.valid && victim_frame.dirty) begin
                            nxt_state = WB1;
                        end else begin
                            nxt_state = RD1;
                        end
                    end
                end

                WB1: begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = blk_addr(victim_frame.tag, dp_addr.idx, 1'b0);
                    mem_req.store = victim_frame.data[0];
                    if (!mem_resp.dwait)
                        nxt_state = WB2;
                end

                WB2: begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = blk_addr(victim_frame.tag, dp_addr.idx, 1'b1);
                    mem_req.store = victim_frame.data[1];
                    if (!mem_resp.dwait)
                        nxt_state = RD1;
                end

                RD1: begin
                    mem_req.ren  = 1'b1;
                    mem_req.addr = blk_addr(dp_addr.tag, dp_addr.idx, 1'b0);
                    if (!mem_resp.dwait) begin
                        nxt_sets[dp_addr.idx].frame[victim].data[0] = mem_resp.load;
                        nxt_state = RD2;
                    end
                end

                RD2: begin
                    mem_req.ren  = 1'b1;
                    mem_req.addr = blk_addr(dp_addr.tag, dp_addr.idx, 1'b1);
                    if (!mem_resp.dwait) begin
                        nxt_sets[dp_addr.idx].frame[victim].data[1] = mem_resp.load;
                        nxt_sets[dp_addr.idx].frame[victim].tag     = dp_addr.tag;
                        nxt_sets[dp_addr.idx].frame[victim].valid   = 1'b1;
                        nxt_sets[dp_addr.idx].frame[victim].dirty   = 1'b0;
                        nxt_state = IDLE;   // retried request hits next cycle
                    end
                end

                FLCHK: begin
                    if (fl_frame.dirty)
                        nxt_state = FL1;
                    else if (row == LAST_ROW)
                        nxt_state = CNTW;
                    else
                        nxt_row = row + 1'b1;
                end

                FL1: begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = blk_addr(fl_frame.tag, fl_idx, 1'b0);
                    mem_req.store = fl_frame.data[0];
                    if (!mem_resp.dwait)
                        nxt_state = FL2;
                end

                FL2: begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = blk_addr(fl_frame.tag, fl_idx, 1'b1);
                    mem_req.store = fl_frame.data[1];
                    if (!mem_resp.dwait) begin
                        nxt_sets[fl_idx].frame[fl_way].dirty = 1'b0;
                        nxt_state = FLCHK;  // clean now, FLCHK moves on
                    end
                end

                CNTW: begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = `HIT_COUNT_ADDR;
                    mem_req.store = hit_count;
                    if (!mem_resp.dwait)
                        nxt_state = STOP;
                end

                STOP: nxt_state = STOP;     // only reset leaves

                default: nxt_state = IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/cache_subsystem.sv */
// data cache plus memory model, snoops come straight in from the ports
// bus_req and bus_resp mirror the cache to memory bus for observation
`default_nettype none

module cache_subsystem import cache_types_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  dp_req_t    dp_req,
    input  logic       halt,
    output dp_resp_t   dp_resp,
    output logic       flushed,
    input  snoop_req_t snoop,
    output logic       ccwrite,
    output word_t      snoop_data,
    output mem_req_t   bus_req,
    output mem_resp_t  bus_resp
);

    dcache u_dcache (
        .CLK        (CLK),
        .nRST       (nRST),
        .dp_req     (dp_req),
        .halt       (halt),
        .dp_resp    (dp_resp),
        .flushed    (flushed),
        .mem_req    (bus_req),
        .mem_resp   (bus_resp),
        .snoop      (snoop),
        .ccwrite    (ccwrite),
        .snoop_data (snoop_data)
    );

    // memory sees no request while a snoop is on the bus
    memory_ram u_memory_ram (
        .CLK      (CLK),
        .nRST     (nRST),
        .mem_req  (bus_req),
        .mem_resp (bus_resp)
    );

endmodule

`default_nettype wire

/* bench/tb_cache_model.svh */
// reference model of cache frames, lru bits, main memory and hit count
// included inside the testbench module, expects cache_types_pkg and the settings macros
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

localparam int IDX_W  = $clog2(`CACHE_SETS);
localparam int MEM_AW = $clog2(`MEM_WORDS);

word_t             m_mem   [`MEM_WORDS];   // unwritten words stay x, like the RAM
logic              m_valid [`CACHE_SETS][2];
logic              m_dirty [`CACHE_SETS][2];
logic [`TAG_W-1:0] m_tag   [`CACHE_SETS][2];
word_t             m_data  [`CACHE_SETS][2][2];
logic              m_lru   [`CACHE_SETS];
int                m_hits;

// bus words the model expects, in order
logic  exp_wen_q  [$];
word_t exp_addr_q [$];
word_t exp_data_q [$];

function automatic word_t make_addr(input logic [`TAG_W-1:0] tag, input int idx,
                                    input logic blk);
    return {tag, IDX_W'(idx), blk, 2'b00};
endfunction

function automatic int mem_index(input word_t addr);
    return int'(addr[MEM_AW+1:2]);
endfunction

task automatic push_expect(input logic wen, input word_t addr, input word_t data);
    exp_wen_q.push_back(wen);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
endtask

task automatic clear_model();
    for (int s = 0; s < `CACHE_SETS; s++) begin
        m_lru[s] = 1'b0;
        for (int w = 0; w < 2; w++) begin
            m_valid[s][w] = 1'b0;
            m_dirty[s][w] = 1'b0;
            m_tag[s][w]   = '0;
            m_data[s][w][0] = '0;
            m_data[s][w][1] = '0;
        end
    end
    m_hits = 0;
endtask

// one datapath access, returns the predicted hit and read value
task automatic predict_access(input word_t addr, input logic wr, input word_t store,
                              output logic hit, output word_t load);
    dcache_addr_t a;
    int s;
    int w;
    a   = dcache_addr_t'(addr);
    s   = a.idx;
    w   = 0;
    hit = 1'b0;
    for (int i = 1; i >= 0; i--) begin
        if (m_valid[s][i] && m_tag[s][i] == a.tag) begin
            hit = 1'b1;
            w   = i;
        end
    end
    if (hit) begin
        m_hits++;
    end else begin
        w = m_lru[s];   // way to replace
        if (m_valid[s][w] && m_dirty[s][w]) begin
            for (int b = 0; b < 2; b++) begin
                push_expect(1'b1, make_addr(m_tag[s][w], s, b[0]), m_data[s][w][b]);
                m_mem[mem_index(make_addr(m_tag[s][w], s, b[0]))] = m_data[s][w][b];
            end
        end
        for (int b = 0; b < 2; b++) begin
            m_data[s][w][b] = m_mem[mem_index(make_addr(a.tag, s, b[0]))];
            push_expect(1'b0, make_addr(a.tag, s, b[0]), m_data[s][w][b]);
        end
        m_tag[s][w]   = a.tag;
        m_valid[s][w] = 1'b1;
        m_dirty[s][w] = 1'b0;
    end
    load = m_data[s][w][a.blkoff];
    if (wr) begin
        m_data[s][w][a.blkoff] = store;
        m_dirty[s][w] = 1'b1;
    end
    m_lru[s] = (w == 0);    // point at the other way
endtask

task automatic predict_snoop(input word_t addr, input logic inv, output logic match,
                             output word_t data);
    dcache_addr_t a;
    int s;
    a     = dcache_addr_t'(addr);
    s     = a.idx;
    match = 1'b0;
    data  = '0;
    for (int i = 1; i >= 0; i--) begin
        if (m_valid[s][i] && m_tag[s][i] == a.tag) begin
            match = 1'b1;
            data  = m_data[s][i][a.blkoff];
            if (inv) begin
                m_valid[s][i] = 1'b0;   // dirty data is dropped too
                m_dirty[s][i] = 1'b0;
            end
        end
    end
endtask

// dirty frames in row order, then the hit count
task automatic expect_flush();
    int s;
    int w;
    for (int r = 0; r < 2 * `CACHE_SETS; r++) begin
        s = r / 2;
        w = r % 2;
        if (m_dirty[s][w]) begin
            for (int b = 0; b < 2; b++)
                push_expect(1'b1, make_addr(m_tag[s][w], s, b[0]), m_data[s][w][b]);
            m_dirty[s][w] = 1'b0;
        end
    end
    push_expect(1'b1, `HIT_COUNT_ADDR, word_t'(m_hits));
endtask

`endif

/* bench/tb_cache_subsystem.sv */
// random traffic on the data cache and memory, checked against a reference model
// snoops and halt come only while no datapath request is pending
`default_nettype none

`include "cache_settings.svh"

module tb_cache_subsystem import cache_types_pkg::*; ();

    localparam int N_WR  = 24;
    localparam int N_RD  = 24;
    localparam int N_MIX = 40;
    localparam int N_LRU = 6;
    localparam int N_SNP = 16;
    localparam int N_REQ = N_WR + N_RD + N_MIX + N_LRU + 2 * N_SNP;
    localparam int MAX_CYCLES = N_REQ * 4 * (`MEM_LATENCY + 1)
                              + 40 * (`MEM_LATENCY + 1) + 200;

    logic       CLK;
    logic       nRST;
    logic       halt;
    dp_req_t    dp_req;
    dp_resp_t   dp_resp;
    logic       flushed;
    snoop_req_t snoop;
    logic       ccwrite;
    word_t      snoop_data;
    mem_req_t   bus_req;
    mem_resp_t  bus_resp;

    integer seed;
    int     cycles = 0;
    int     errors;
    int     n_tests;
    int     n_failed;
    word_t  written_q [$];      // only these are read back

    // completed bus words seen during one request or the flush
    logic  bus_wen_q  [$];
    word_t bus_addr_q [$];
    word_t bus_data_q [$];

    `include "tb_cache_model.svh"

    cache_subsystem UUT (
        .CLK        (CLK),
        .nRST       (nRST),
        .dp_req     (dp_req),
        .halt       (halt),
        .dp_resp    (dp_resp),
        .flushed    (flushed),
        .snoop      (snoop),
        .ccwrite    (ccwrite),
        .snoop_data (snoop_data),
        .bus_req    (bus_req),
        .bus_resp   (bus_resp)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles, the cache never finished", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t pool_addr(input int t, input int s, input int b);
        return make_addr(`TAG_W'(t + 1), s, b[0]);
    endfunction

    task automatic note_bus_word();
        if ((bus_req.ren || bus_req.wen) && !bus_resp.dwait) begin
            bus_wen_q.push_back(bus_req.wen);
            bus_addr_q.push_back(bus_req.addr);
            bus_data_q.push_back(bus_req.wen ? bus_req.store : bus_resp.load);
        end
    endtask

    task automatic compare_bus();
        check("bus word count", bus_addr_q.size(), exp_addr_q.size());
        for (int i = 0; i < bus_addr_q.size() && i < exp_addr_q.size(); i++) begin
            check("bus_req.wen", bus_wen_q[i], exp_wen_q[i]);
            check("bus_req.addr", bus_addr_q[i], exp_addr_q[i]);
            check("bus data", bus_data_q[i], exp_data_q[i]);
        end
        bus_wen_q.delete();
        bus_addr_q.delete();
        bus_data_q.delete();
        exp_wen_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    // one datapath access held until dhit, reads returns the bus reads seen
    task automatic do_request(input logic wr, input word_t addr, input word_t store,
                              output int reads);
        logic  exp_hit;
        word_t exp_load;
        int    bus_cycles;
        predict_access(addr, wr, store, exp_hit, exp_load);
        bus_cycles = 0;
        @(posedge CLK);
        dp_req <= '{ren: !wr, wen: wr, addr: addr, store: store};
        do begin
            @(negedge CLK);
            note_bus_word();
            if (bus_req.ren || bus_req.wen)
                bus_cycles++;
        end while (!dp_resp.dhit);
        if (!wr)
            check("dp_resp.load", dp_resp.load, exp_load);
        if (exp_hit)
            check("bus cycles before hit", bus_cycles, 0);
        else
            check("bus cycles for miss", bus_cycles,
                  exp_addr_q.size() * (`MEM_LATENCY + 1));   // each word waits its latency
        reads = 0;
        foreach (bus_wen_q[i])
            if (!bus_wen_q[i])
                reads++;
        compare_bus();
        if (wr)
            written_q.push_back(addr);
        @(posedge CLK);
        dp_req <= '0;
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        n_tests++;
        if (errors == errs_at_start) begin
            $display("test %0d %s: ok", n_tests, name);
        end else begin
            n_failed++;
            $display("test %0d %s: %0d mismatches", n_tests, name, errors - errs_at_start);
        end
    endtask

    task automatic run_snoops();
        word_t addr;
        logic  inv;
        logic  exp_match;
        word_t exp_data;
        int    s;
        int    w;
        int    reads;
        for (int n = 0; n < N_SNP; n++) begin
            addr = pool_addr(rand_below(3), rand_below(`CACHE_SETS), rand_below(2));
            s    = rand_below(`CACHE_SETS);
            w    = rand_below(2);
            if (rand_below(2) == 1 && m_valid[s][w])
                addr = make_addr(m_tag[s][w], s, rand_below(2) == 1);   // a cached block
            inv = (rand_below(4) == 0);
            predict_snoop(addr, inv, exp_match, exp_data);
            @(posedge CLK);
            snoop <= '{active: 1'b1, inv: inv, addr: addr};
            @(negedge CLK);
            check("ccwrite", ccwrite, exp_match);
            if (exp_match)
                check("snoop_data", snoop_data, exp_data);
            check("bus_req.ren|wen during snoop", bus_req.ren | bus_req.wen, 0);
            check("bus_req.addr during snoop", bus_req.addr, addr);
            @(posedge CLK);
            snoop <= '0;
            if (inv && exp_match) begin
                do_request(1'b1, addr, $random(seed), reads);
                check("bus reads after invalidate", reads, 2);
            end
        end
    endtask

    initial begin
        int    mark;
        int    reads;
        int    set;
        word_t addr;
        seed     = 32'h4f11_2cbd;
        errors   = 0;
        n_tests  = 0;
        n_failed = 0;
        nRST   <= 1'b0;
        halt   <= 1'b0;
        dp_req <= '0;
        snoop  <= '0;
        clear_model();
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;

        mark = errors;
        @(negedge CLK);
        check("bus_req.ren|wen after reset", bus_req.ren | bus_req.wen, 0);
        check("bus_resp.dwait after reset", bus_resp.dwait, 0);
        check("dp_resp.dhit after reset", dp_resp.dhit, 0);
        check("ccwrite after reset", ccwrite, 0);
        check("flushed after reset", flushed, 0);
        for (int n = 0; n < N_WR; n++) begin
            addr = pool_addr(rand_below(3), rand_below(`CACHE_SETS), rand_below(2));
            do_request(1'b1, addr, $random(seed), reads);
        end
        for (int n = 0; n < N_RD; n++)
            do_request(1'b0, written_q[rand_below(written_q.size())], '0, reads);
        finish_test("read after write", mark);

        mark = errors;
        for (int n = 0; n < N_MIX; n++) begin
            if (rand_below(2) == 1)
                do_request(1'b0, written_q[rand_below(written_q.size())], '0, reads);
            else
                do_request(1'b1, pool_addr(rand_below(3), rand_below(`CACHE_SETS),
                                           rand_below(2)), $random(seed), reads);
        end
        finish_test("miss traffic", mark);

        // A, B, A, C in one set leaves A and C resident
        mark = errors;
        set  = rand_below(`CACHE_SETS);
        do_request(1'b1, pool_addr(0, set, 0), $random(seed), reads);
        do_request(1'b1, pool_addr(1, set, 0), $random(seed), reads);
        do_request(1'b1, pool_addr(0, set, 0), $random(seed), reads);
        do_request(1'b1, pool_addr(2, set, 0), $random(seed), reads);
        do_request(1'b0, pool_addr(0, set, 0), '0, reads);
        check("bus reads for A", reads, 0);
        do_request(1'b0, pool_addr(1, set, 0), '0, reads);
        check("bus reads for B", reads, 2);
        finish_test("lru replacement", mark);

        mark = errors;
        run_snoops();
        finish_test("snoop", mark);

        mark = errors;
        expect_flush();
        @(posedge CLK);
        halt <= 1'b1;
        do begin
            @(negedge CLK);
            note_bus_word();
        end while (!flushed);
        compare_bus();
        repeat (4) begin
            @(negedge CLK);
            check("flushed", flushed, 1);
            check("bus_req.ren|wen after flush", bus_req.ren | bus_req.wen, 0);
        end
        finish_test("flush", mark);

        $display("%0d tests, %0d failed, %0d mismatches", n_tests, n_failed, errors);
        if (n_failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
+incdir+bench
common/cache_types_pkg.sv
logic/memory_ram.sv
dcache/dcache.sv
logic/cache_subsystem.sv
bench/tb_cache_subsystem.sv
